/* project.f */
+incdir+common
common/soc_pkg.sv
design/bus_decoder.sv
design/mem_slave.sv
design/io_regs.sv
pic/simple_pic.sv
design/pit_timer.sv
design/soc_top.sv
sim/tb_soc.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and reports pass or fail
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc -f project.f -o sim_soc
out=$(./obj_dir/sim_soc 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1

/* sim/tb_soc.sv */
// Testbench for the bus subsystem, drives the master port and checks the answers by assertions
`include "soc_consts.svh"

module tb_soc;

  // Memory, I/O and three timer rounds need about 1500 cycles, the rest is margin
  localparam int CYCLE_LIMIT = 20000;
  localparam int ACK_LIMIT = 16;
  localparam int MEM_SLOTS = 16;
  localparam int MEM_OPS = 80;

  logic              clk;
  logic              rst_i;
  soc_pkg::bus_req_t req;
  logic              inta;
  logic [6:0]        irq;
  soc_pkg::word_t    sw;
  soc_pkg::bus_rsp_t rsp;
  logic              intr;
  soc_pkg::word_t    led;

  // Expected values, all written on falling edges
  logic           chk_rd;
  soc_pkg::word_t exp_rdat;
  soc_pkg::word_t exp_vec;
  soc_pkg::word_t exp_led;
  logic           intr_known;
  logic           exp_intr;
  logic           timer_chk;

  logic           ack_q;
  int             rel_cnt;
  int             cyc;
  int             chk_errs;
  int             proto_errs;
  logic [15:0]    lfsr;
  soc_pkg::word_t model_mem [2 ** `MEM_ADDR_BITS];
  soc_pkg::addr_t slot_adr [MEM_SLOTS];

  soc_top i_dut (
    .clk    (clk),
    .rst_i  (rst_i),
    .req_i  (req),
    .inta_i (inta),
    .irq_i  (irq),
    .sw_i   (sw),
    .rsp_o  (rsp),
    .intr_o (intr),
    .led_o  (led)
  );

  always #4 clk = ~clk;

  // Ack seen at the last rising edge, read by the bus task on the falling edge
  always @(posedge clk) begin
    ack_q <= rsp.ack;
  end

  // Rising edges since reset release, the timer period counts from there
  always @(posedge clk) begin
    if (rst_i) begin
      rel_cnt <= 0;
    end else begin
      rel_cnt <= rel_cnt + 1;
    end
  end

  task automatic flag_mismatch(input string msg);
    chk_errs++;
    $display("** Error at %0t: %s", $time, msg);
  endtask

  a_reset_state: assert property (
    @(posedge clk) $fell(rst_i) |-> !rsp.ack && !intr && led == '0
  ) else flag_mismatch("outputs not idle after reset");

  // First strobe cycle of a memory access
  a_mem_wait: assert property (
    @(posedge clk) disable iff (rst_i)
      req.stb && !req.tga && !inta && !$past(req.stb) |-> !rsp.ack
  ) else flag_mismatch("memory ack without a wait state");

  a_mem_ack: assert property (
    @(posedge clk) disable iff (rst_i)
      req.stb && !req.tga && !inta && !$past(req.stb) |=> rsp.ack
  ) else flag_mismatch("memory ack missing one cycle after strobe");

  a_io_ack: assert property (
    @(posedge clk) disable iff (rst_i) req.stb && req.tga && !inta |-> rsp.ack
  ) else flag_mismatch("I/O access not acknowledged in its strobe cycle");

  a_read: assert property (
    @(posedge clk) disable iff (rst_i) chk_rd && rsp.ack |-> rsp.dat == exp_rdat
  ) else flag_mismatch($sformatf("read data %h, expected %h", rsp.dat, exp_rdat));

  a_vector: assert property (
    @(posedge clk) disable iff (rst_i) inta |-> rsp.ack && rsp.dat == exp_vec
  ) else flag_mismatch($sformatf("vector %h, expected %h", rsp.dat, exp_vec));

  a_led: assert property (
    @(posedge clk) disable iff (rst_i) led == exp_led
  ) else flag_mismatch($sformatf("led_o %h, expected %h", led, exp_led));

  a_intr: assert property (
    @(posedge clk) disable iff (rst_i) intr_known |-> intr == exp_intr
  ) else flag_mismatch("intr_o differs from the pending set");

  // A tick rises intr one edge after each full period
  a_tick: assert property (
    @(posedge clk) disable iff (rst_i)
      timer_chk && $rose(intr) |-> (rel_cnt % `TIMER_PERIOD) == 0
  ) else flag_mismatch("timer interrupt off its period");

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // One stb/ack access, also keeps the RAM and LED models up to date
  task automatic bus_access(input soc_pkg::addr_t adr, input logic tga, input logic we,
                            input soc_pkg::sel_t sel, input soc_pkg::word_t dat,
                            input soc_pkg::word_t exp);
    int waited;
    logic [`MEM_ADDR_BITS-1:0] idx;
    idx = adr[`MEM_ADDR_BITS:1];
    req.adr = adr;
    req.tga = tga;
    req.we = we;
    req.sel = sel;
    req.dat = dat;
    req.stb = 1'b1;
    chk_rd = !we;
    exp_rdat = tga ? exp : model_mem[idx];
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!ack_q && waited < ACK_LIMIT);
    if (!ack_q) begin
      proto_errs++;
      $display("No acknowledge for the access to address %h", adr);
    end
    if (tga && we && adr[15:8] == `LED_PORT_HI) begin
      exp_led = dat;
    end
    if (!tga && we && sel[0]) begin
      model_mem[idx][7:0] = dat[7:0];
    end
    if (!tga && we && sel[1]) begin
      model_mem[idx][15:8] = dat[15:8];
    end
    req.stb = 1'b0;
    req.we = 1'b0;
    chk_rd = 1'b0;
    @(negedge clk);
  endtask

  task automatic inta_pulse(input soc_pkg::word_t vec);
    exp_vec = vec;
    inta = 1'b1;
    @(negedge clk);
    inta = 1'b0;
  endtask

  initial begin
    logic [31:0]    r;
    logic [15:1]    port;
    logic [6:0]     mask;
    soc_pkg::sel_t  sel;
    int             left;
    int             waited;
    clk = 1'b0;
    rst_i = 1'b1;
    req = '0;
    inta = 1'b0;
    irq = '0;
    sw = '0;
    chk_rd = 1'b0;
    exp_rdat = '0;
    exp_vec = '0;
    exp_led = '0;
    intr_known = 1'b0;
    exp_intr = 1'b0;
    timer_chk = 1'b0;
    chk_errs = 0;
    proto_errs = 0;
    lfsr = 16'd29020;
    repeat (10) @(negedge clk);
    rst_i = 1'b0;
    @(negedge clk);

    // Fill the slots with whole words first so every later read is defined
    for (int i = 0; i < MEM_SLOTS; i++) begin
      draw_bits(19, r);
      slot_adr[i] = r[18:0];
      draw_bits(16, r);
      bus_access(slot_adr[i], 1'b0, 1'b1, 2'b11, r[15:0], '0);
    end
    for (int i = 0; i < MEM_OPS; i++) begin
      draw_bits(3, r);
      sel = r[2:1];
      if (r[0]) begin
        draw_bits(16, r);
        bus_access(slot_adr[i % MEM_SLOTS], 1'b0, 1'b1, sel, r[15:0], '0);
      end else begin
        bus_access(slot_adr[(i * 7) % MEM_SLOTS], 1'b0, 1'b0, 2'b11, '0, '0);
      end
    end
    for (int i = 0; i < MEM_SLOTS; i++) begin
      bus_access(slot_adr[i], 1'b0, 1'b0, 2'b11, '0, '0);
    end

    // LED writes and read-back through another port of the LED range
    for (int i = 0; i < 4; i++) begin
      draw_bits(7, r);
      port = {`LED_PORT_HI, r[6:0]};
      draw_bits(16, r);
      bus_access({4'h0, port}, 1'b1, 1'b1, 2'b11, r[15:0], '0);
      draw_bits(7, r);
      port = {`LED_PORT_HI, r[6:0]};
      bus_access({4'h0, port}, 1'b1, 1'b0, 2'b11, '0, exp_led);
    end
    for (int i = 0; i < 3; i++) begin
      draw_bits(16, r);
      sw = r[15:0];
      bus_access({4'h0, 15'(`SW_PORT)}, 1'b1, 1'b0, 2'b11, '0, sw);
    end
    bus_access({4'h0, 15'(`KB_STAT_PORT)}, 1'b1, 1'b0, 2'b11, '0, 16'h0010);
    for (int i = 0; i < 8; i++) begin
      do begin
        draw_bits(15, r);
        port = r[14:0];
      end while (port[15:8] == `LED_PORT_HI || port == `SW_PORT || port == `KB_STAT_PORT);
      draw_bits(16, r);
      bus_access({4'h0, port}, 1'b1, 1'b1, 2'b11, r[15:0], '0);
      bus_access({4'h0, port}, 1'b1, 1'b0, 2'b11, '0, 16'hFFFF);
    end

    for (int round = 0; round < 3; round++) begin
      // Clear a stale tick, then catch the next one
      if (intr) begin
        inta_pulse(soc_pkg::word_t'(`VECTOR_BASE));
      end
      timer_chk = 1'b1;
      waited = 0;
      while (!intr && waited < 2 * `TIMER_PERIOD) begin
        @(negedge clk);
        waited++;
      end
      if (!intr) begin
        proto_errs++;
        $display("Timer interrupt did not arrive within two periods");
      end else begin
        inta_pulse(soc_pkg::word_t'(`VECTOR_BASE));
        intr_known = 1'b1;
        exp_intr = 1'b0;
        repeat (3) @(negedge clk);
        intr_known = 1'b0;
      end
      timer_chk = 1'b0;

      // Several lines at once, served lowest line first
      do begin
        draw_bits(7, r);
        mask = r[6:0];
      end while (mask == '0);
      irq = mask;
      @(negedge clk);
      intr_known = 1'b1;
      exp_intr = 1'b1;
      left = $countones(mask);
      for (int i = 0; i < 7; i++) begin
        if (mask[i]) begin
          inta_pulse(soc_pkg::word_t'(`VECTOR_BASE + i + 1));
          left--;
          if (left == 0) begin
            exp_intr = 1'b0;
          end
          @(negedge clk);
        end
      end
      irq = '0;
      @(negedge clk);
      intr_known = 1'b0;
    end

    repeat (2) @(negedge clk);
    $display("Check errors: %0d, other failures: %0d", chk_errs, proto_errs);
    if (chk_errs == 0 && proto_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    cyc = 0;
    while (cyc < CYCLE_LIMIT) begin
      @(posedge clk);
      cyc++;
    end
    $display("Run stopped at the cycle limit of %0d cycles", CYCLE_LIMIT);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* design/soc_top.sv */
// Bus subsystem top level, the master port is driven by the CPU or the testbench
module soc_top (
  input  logic              clk,
  input  logic              rst_i,
  input  soc_pkg::bus_req_t req_i,
  input  logic              inta_i,
  input  logic [6:0]        irq_i,
  input  soc_pkg::word_t    sw_i,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic              intr_o,
  output soc_pkg::word_t    led_o
);

  soc_pkg::bus_req_t mem_req;
  soc_pkg::bus_rsp_t mem_rsp;
  soc_pkg::bus_req_t io_req;
  soc_pkg::bus_rsp_t io_rsp;
  soc_pkg::iid_t     iid;
  soc_pkg::irq_vec_t irq_vec;
  logic              tick;

  // Timer owns line 0
  assign irq_vec = {irq_i, tick};

  bus_decoder i_decoder (
    .req_i     (req_i),
    .inta_i    (inta_i),
    .iid_i     (iid),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp),
    .io_req_o  (io_req),
    .io_rsp_i  (io_rsp),
    .rsp_o     (rsp_o)
  );

  mem_slave i_mem (
    .clk   (clk),
    .rst_i (rst_i),
    .req_i (mem_req),
    .rsp_o (mem_rsp)
  );

  io_regs i_io (
    .clk   (clk),
    .rst_i (rst_i),
    .req_i (io_req),
    .sw_i  (sw_i),
    .led_o (led_o),
    .rsp_o (io_rsp)
  );

  simple_pic i_pic (
    .clk    (clk),
    .rst_i  (rst_i),
    .irq_i  (irq_vec),
    .inta_i (inta_i),
    .intr_o (intr_o),
    .iid_o  (iid)
  );

  pit_timer i_timer (
    .clk    (clk),
    .rst_i  (rst_i),
    .tick_o (tick)
  );

endmodule

/* design/pit_timer.sv */
// Periodic timer that pulses interrupt line 0 every timer period
`include "soc_consts.svh"

module pit_timer (
  input  logic clk,
  input  logic rst_i,
  output logic tick_o
);

  localparam int CNT_W = $clog2(`TIMER_PERIOD);

  logic [CNT_W-1:0] cnt_q;

  // Down-counter, reloaded on wrap
  always_ff @(posedge clk) begin
    if (rst_i) begin
      cnt_q <= CNT_W'(`TIMER_PERIOD - 1);
    end else if (cnt_q == '0) begin
      cnt_q <= CNT_W'(`TIMER_PERIOD - 1);
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // One cycle wide, the PIC sees it as an edge
  assign tick_o = (cnt_q == '0);

endmodule

/* pic/simple_pic.sv */
// Eight-line edge-triggered priority interrupt controller with an acknowledge cycle
module simple_pic (
  input  logic              clk,
  input  logic              rst_i,
  input  soc_pkg::irq_vec_t irq_i,
  input  logic              inta_i,
  output logic              intr_o,
  output soc_pkg::iid_t     iid_o
);

  soc_pkg::irq_vec_t irq_prev_q;
  soc_pkg::irq_vec_t pending_q;
  soc_pkg::irq_vec_t edges;
  soc_pkg::irq_vec_t clear;

  // Rising edges only, a held line does not retrigger
  assign edges = irq_i & ~irq_prev_q;

  // Line being acknowledged this cycle
  always_comb begin
    clear = '0;
    if (inta_i) begin
      clear[iid_o] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      irq_prev_q <= '0;
      pending_q  <= '0;
    end else begin
      irq_prev_q <= irq_i;
      // A new edge wins over a clear on the same line
      pending_q  <= (pending_q & ~clear) | edges;
    end
  end

  // Lowest-numbered pending line has priority
  always_comb begin
    iid_o = '0;
    for (int i = 7; i >= 0; i--) begin
      if (pending_q[i]) begin
        iid_o = soc_pkg::iid_t'(i);
      end
    end
  end

  assign intr_o = |pending_q;

  // Master may only acknowledge an interrupt that is being requested
  a_inta_with_intr: assert property (
    @(posedge clk) disable iff (rst_i) inta_i |-> intr_o
  ) else $error("interrupt acknowledge without a pending request");

endmodule

/* design/io_regs.sv */
// I/O port block with the LED register, switch port, keyboard status and unmapped reads
`include "soc_consts.svh"

module io_regs (
  input  logic              clk,
  input  logic              rst_i,
  input  soc_pkg::bus_req_t req_i,
  input  soc_pkg::word_t    sw_i,
  output soc_pkg::word_t    led_o,
  output soc_pkg::bus_rsp_t rsp_o
);

  soc_pkg::word_t led_q;
  logic           led_port;
  logic           sw_port;
  logic           kb_stat_port;

  // Any port in the F1xx range reaches the LEDs
  assign led_port     = (req_i.adr[15:8] == `LED_PORT_HI);
  assign sw_port      = (req_i.adr[15:1] == `SW_PORT);
  assign kb_stat_port = (req_i.adr[15:1] == `KB_STAT_PORT);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      led_q <= '0;
    end else if (req_i.stb && req_i.we && led_port) begin
      led_q <= req_i.dat;
    end
  end

  always_comb begin
    if (led_port) begin
      rsp_o.dat = led_q;
    end else if (sw_port) begin
      rsp_o.dat = sw_i;
    end else if (kb_stat_port) begin
      // Reports the keyboard as not inhibited
      rsp_o.dat = `KB_STAT_VALUE;
    end else begin
      rsp_o.dat = `UNMAPPED_VALUE;
    end
  end

  // No wait states on I/O
  assign rsp_o.ack = req_i.stb;

  assign led_o = led_q;

endmodule

/* design/mem_slave.sv */
// On-chip word RAM slave with byte lanes and one wait state, standing in for external memory
`include "soc_consts.svh"

module mem_slave (
  input  logic              clk,
  input  logic              rst_i,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o
);

  localparam int DEPTH = 2 ** `MEM_ADDR_BITS;

  soc_pkg::word_t            mem [DEPTH];
  soc_pkg::word_t            rdat_q;
  soc_pkg::mem_state_e       state_q;
  logic [`MEM_ADDR_BITS-1:0] idx;
  logic                      wr_en;

  // Low word-address bits pick the RAM entry, upper bits alias
  assign idx = req_i.adr[`MEM_ADDR_BITS:1];

  // Write lands on the edge where the master sees ack
  assign wr_en = (state_q == soc_pkg::ACK) && req_i.stb && req_i.we;

  // Wait-state FSM, ack is the registered state
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= soc_pkg::IDLE;
    end else begin
      case (state_q)
        soc_pkg::IDLE: if (req_i.stb) state_q <= soc_pkg::ACK;
        soc_pkg::ACK:  state_q <= soc_pkg::IDLE;
        default:       state_q <= soc_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && req_i.sel[0]) begin
      mem[idx][7:0] <= req_i.dat[7:0];
    end
    if (wr_en && req_i.sel[1]) begin
      mem[idx][15:8] <= req_i.dat[15:8];
    end
    // Read data captured during the wait state
    if (state_q == soc_pkg::IDLE && req_i.stb) begin
      rdat_q <= mem[idx];
    end
  end

  assign rsp_o.dat = rdat_q;
  assign rsp_o.ack = (state_q == soc_pkg::ACK);

  // Every ack falls inside a strobe that was already high one cycle earlier
  a_ack_after_stb: assert property (
    @(posedge clk) disable iff (rst_i) rsp_o.ack |-> req_i.stb && $past(req_i.stb)
  ) else $error("memory ack without a held strobe");

endmodule

/* design/bus_decoder.sv */
// Arena decoder that routes each master access to memory or I/O and returns the answer
`include "soc_consts.svh"

module bus_decoder (
  input  soc_pkg::bus_req_t req_i,
  input  logic              inta_i,
  input  soc_pkg::iid_t     iid_i,
  output soc_pkg::bus_req_t mem_req_o,
  input  soc_pkg::bus_rsp_t mem_rsp_i,
  output soc_pkg::bus_req_t io_req_o,
  input  soc_pkg::bus_rsp_t io_rsp_i,
  output soc_pkg::bus_rsp_t rsp_o
);

  logic          mem_arena;
  logic          io_arena;
  logic          mem_stb;
  logic          io_stb;
  soc_pkg::word_t vector;

  // tga selects the I/O space, everything else is memory
  assign io_arena  = req_i.tga;
  assign mem_arena = !req_i.tga;

  // Interrupt acknowledge owns the bus for its cycle
  assign mem_stb = req_i.stb && mem_arena && !inta_i;
  assign io_stb  = req_i.stb && io_arena && !inta_i;

  assign vector = soc_pkg::word_t'(`VECTOR_BASE) + soc_pkg::word_t'(iid_i);

  // Both slaves see the same request, only the strobe differs
  always_comb begin
    mem_req_o     = req_i;
    mem_req_o.stb = mem_stb;
    io_req_o      = req_i;
    io_req_o.stb  = io_stb;
  end

  // Answer path back to the master
  always_comb begin
    if (inta_i) begin
      // Vector is read in the same cycle as the acknowledge pulse
      rsp_o.dat = vector;
      rsp_o.ack = 1'b1;
    end else if (io_arena) begin
      rsp_o = io_rsp_i;
    end else begin
      rsp_o = mem_rsp_i;
    end
  end

endmodule

/* common/soc_pkg.sv */
// Bus types shared by the system-bus decoder, its slaves and the interrupt path
package soc_pkg;

  // Data, address and lane widths of the 16-bit system bus
  typedef logic [15:0] word_t;
  typedef logic [19:1] addr_t;
  typedef logic [1:0]  sel_t;

  // Interrupt lines and interrupt number
  typedef logic [7:0] irq_vec_t;
  typedef logic [2:0] iid_t;

  // One master request, held stable until ack
  typedef struct packed {
    addr_t adr;
    word_t dat;
    logic  we;
    logic  tga;
    sel_t  sel;
    logic  stb;
  } bus_req_t;

  // One slave answer
  typedef struct packed {
    word_t dat;
    logic  ack;
  } bus_rsp_t;

  // Memory slave FSM
  typedef enum logic {IDLE, ACK} mem_state_e;

endpackage

/* common/soc_consts.svh */
// Sizes, periods and I/O port numbers of the bus subsystem, included by the RTL that uses them
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// RAM word-address bits, 1024 words
`define MEM_ADDR_BITS 10

// Clock cycles between timer ticks
`define TIMER_PERIOD 200

// High byte shared by all LED ports
`define LED_PORT_HI 8'hF1

// Word addresses of the fixed input ports
`define SW_PORT 15'h0081
`define KB_STAT_PORT 15'h0032

// Read values of the keyboard status port and of unmapped ports
`define KB_STAT_VALUE 16'h0010
`define UNMAPPED_VALUE 16'hFFFF

// Interrupt vector returned is this base plus the iid
`define VECTOR_BASE 8

`endif
